// File: verilog/isa_pkg.sv
package isa_pkg;

   localparam int XLEN       = 32;
   localparam int REG_ADDR_W = 5;

   // Major opcode, instruction bits 6..2
   typedef enum logic [4:0] {
      OPC_LOAD     = 5'b00000,
      OPC_MISC_MEM = 5'b00011,
      OPC_OP_IMM   = 5'b00100,
      OPC_AUIPC    = 5'b00101,
      OPC_STORE    = 5'b01000,
      OPC_OP       = 5'b01100,
      OPC_LUI      = 5'b01101,
      OPC_BRANCH   = 5'b11000,
      OPC_JALR     = 5'b11001,
      OPC_JAL      = 5'b11011,
      OPC_SYSTEM   = 5'b11100
   } opcode_t;

   // OP and OP-IMM
   localparam logic [2:0] F3_ADD_SUB = 3'b000;
   localparam logic [2:0] F3_SLL     = 3'b001;
   localparam logic [2:0] F3_SLT     = 3'b010;
   localparam logic [2:0] F3_SLTU    = 3'b011;
   localparam logic [2:0] F3_XOR     = 3'b100;
   localparam logic [2:0] F3_SR      = 3'b101;  // SRL or SRA
   localparam logic [2:0] F3_OR      = 3'b110;
   localparam logic [2:0] F3_AND     = 3'b111;

   // Loads and stores
   localparam logic [2:0] F3_LB  = 3'b000;
   localparam logic [2:0] F3_LH  = 3'b001;
   localparam logic [2:0] F3_LW  = 3'b010;
   localparam logic [2:0] F3_LBU = 3'b100;
   localparam logic [2:0] F3_LHU = 3'b101;
   localparam logic [2:0] F3_SB  = 3'b000;
   localparam logic [2:0] F3_SH  = 3'b001;
   localparam logic [2:0] F3_SW  = 3'b010;

   // Branches
   localparam logic [2:0] F3_BEQ  = 3'b000;
   localparam logic [2:0] F3_BNE  = 3'b001;
   localparam logic [2:0] F3_BLT  = 3'b100;
   localparam logic [2:0] F3_BGE  = 3'b101;
   localparam logic [2:0] F3_BLTU = 3'b110;
   localparam logic [2:0] F3_BGEU = 3'b111;

   // SYSTEM, funct3 and the sub-code in imm[2:0]
   localparam logic [2:0] F3_PRIV   = 3'b000;
   localparam logic [2:0] F3_CSRRW  = 3'b001;
   localparam logic [2:0] F3_CSRRS  = 3'b010;
   localparam logic [2:0] F3_CSRRC  = 3'b011;
   localparam logic [2:0] F3_CSRRWI = 3'b101;
   localparam logic [2:0] F3_CSRRSI = 3'b110;
   localparam logic [2:0] F3_CSRRCI = 3'b111;
   localparam logic [2:0] SYS_ECALL  = 3'b000;
   localparam logic [2:0] SYS_EBREAK = 3'b001;
   localparam logic [2:0] SYS_MRET   = 3'b010;
   localparam logic [2:0] SYS_WFI    = 3'b101;

   typedef struct packed {
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
      logic [1:0]            quad;  // 2'b11 for 32-bit encodings
   } r_type_t;

   typedef struct packed {
      logic [11:0]           imm_11_0;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
      logic [1:0]            quad;
   } i_type_t;

   typedef struct packed {
      logic [6:0]            imm_11_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [4:0]            imm_4_0;
      opcode_t               opcode;
      logic [1:0]            quad;
   } s_type_t;

   typedef struct packed {
      logic                  imm_12;
      logic [5:0]            imm_10_5;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rs1;
      logic [2:0]            funct3;
      logic [3:0]            imm_4_1;
      logic                  imm_11;
      opcode_t               opcode;
      logic [1:0]            quad;
   } b_type_t;

   typedef struct packed {
      logic [19:0]           imm_31_12;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
      logic [1:0]            quad;
   } u_type_t;

   typedef struct packed {
      logic                  imm_20;
      logic [9:0]            imm_10_1;
      logic                  imm_11;
      logic [7:0]            imm_19_12;
      logic [REG_ADDR_W-1:0] rd;
      opcode_t               opcode;
      logic [1:0]            quad;
   } j_type_t;

   typedef union packed {
      r_type_t r;
      i_type_t i;
      s_type_t s;
      b_type_t b;
      u_type_t u;
      j_type_t j;
   } instr_u;

   typedef struct packed {
      opcode_t               opcode;
      logic [2:0]            funct3;
      logic [6:0]            funct7;
      logic [REG_ADDR_W-1:0] rs1;
      logic [REG_ADDR_W-1:0] rs2;
      logic [REG_ADDR_W-1:0] rd;
   } decoded_instr_t;

endpackage

// File: verilog/ctrl_pkg.sv
package ctrl_pkg;

   localparam int EXC_CAUSE_W = 32;

   localparam logic [EXC_CAUSE_W-1:0] EXC_ILLEGAL = 32'd2;
   localparam logic [EXC_CAUSE_W-1:0] EXC_BREAK   = 32'd3;
   localparam logic [EXC_CAUSE_W-1:0] EXC_ECALL   = 32'd11;  // ECALL from M-mode

   typedef enum logic [3:0] {
      ALU_ADD  = 4'h0,
      ALU_SUB  = 4'h1,
      ALU_SLL  = 4'h2,
      ALU_SLT  = 4'h3,
      ALU_SLTU = 4'h4,
      ALU_XOR  = 4'h5,
      ALU_SRL  = 4'h6,
      ALU_SRA  = 4'h7,
      ALU_OR   = 4'h8,
      ALU_AND  = 4'h9,
      ALU_CE   = 4'ha,  // Branch compares
      ALU_CNE  = 4'hb,
      ALU_CGE  = 4'hc,
      ALU_CGEU = 4'hd
   } alu_op_t;

   typedef enum logic [3:0] {
      MEM_NOP = 4'h0,
      MEM_LB  = 4'h1,
      MEM_LH  = 4'h2,
      MEM_LW  = 4'h3,
      MEM_LBU = 4'h4,
      MEM_LHU = 4'h5,
      MEM_SB  = 4'h6,
      MEM_SH  = 4'h7,
      MEM_SW  = 4'h8
   } mem_type_t;

   // Register write-back source
   typedef enum logic [1:0] {
      WB_ALU = 2'b00,
      WB_PC4 = 2'b01,
      WB_CSR = 2'b10,
      WB_IMM = 2'b11
   } wb_sel_t;

   typedef enum logic [1:0] {
      CSR_NOP = 2'b00,
      CSR_RW  = 2'b01,
      CSR_RS  = 2'b10,
      CSR_RC  = 2'b11
   } csr_op_t;

   typedef struct packed {
      mem_type_t              mem_type;
      logic                   reg_write;
      logic                   mem_to_reg;
      logic                   alu_from_imm;  // Operand B
      logic                   alu_from_pc;   // Operand A
      alu_op_t                alu_op;
      wb_sel_t                wb_sel;
      logic                   is_branch;
      logic                   is_jal;
      logic                   is_jalr;
      logic                   inst_invalid;
      logic                   inst_priv;
      logic                   exc_request;
      logic                   exc_ret;       // MRET
      logic                   csr_from_reg;  // rs1, else uimm
      csr_op_t                csr_op;
      logic [EXC_CAUSE_W-1:0] exc_cause;
   } control_out_t;

endpackage

// File: verilog/instr_decoder.sv
`timescale 1ns/1ns

module instr_decoder import isa_pkg::*; (
   input  logic [XLEN-1:0] instr_i,
   output decoded_instr_t  fields_o,
   output logic [XLEN-1:0] imm_o
);

   instr_u word;

   assign word = instr_i;

   // Register fields sit at the same place in every format
   assign fields_o.opcode = word.r.opcode;
   assign fields_o.funct3 = word.r.funct3;
   assign fields_o.funct7 = word.r.funct7;
   assign fields_o.rs1    = word.r.rs1;
   assign fields_o.rs2    = word.r.rs2;
   assign fields_o.rd     = word.r.rd;

   always_comb begin
      imm_o = '0;
      unique case (word.r.opcode)
         OPC_LOAD,
         OPC_OP_IMM,
         OPC_JALR,
         OPC_SYSTEM: begin
            imm_o = {{(XLEN-12){word.i.imm_11_0[11]}}, word.i.imm_11_0};
         end
         OPC_STORE: begin
            imm_o = {{(XLEN-12){word.s.imm_11_5[6]}},
                     word.s.imm_11_5,
                     word.s.imm_4_0};
         end
         OPC_BRANCH: begin
            imm_o = {{(XLEN-12){word.b.imm_12}},
                     word.b.imm_11,
                     word.b.imm_10_5,
                     word.b.imm_4_1,
                     1'b0};  // Halfword aligned
         end
         OPC_LUI,
         OPC_AUIPC: begin
            imm_o = {word.u.imm_31_12, 12'b0};  // Upper, no extension
         end
         OPC_JAL: begin
            imm_o = {{(XLEN-20){word.j.imm_20}},
                     word.j.imm_19_12,
                     word.j.imm_11,
                     word.j.imm_10_1,
                     1'b0};
         end
         default: begin
            imm_o = '0;  // MISC-MEM, OP and unused opcodes
         end
      endcase
   end

endmodule

// File: verilog/control_unit.sv
`timescale 1ns/1ns

module control_unit import isa_pkg::*, ctrl_pkg::*; (
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic            decode_i,
   input  decoded_instr_t  instr_i,
   input  logic [XLEN-1:0] imm_i,
   output control_out_t    control_o
);

   control_out_t ctrl_next;
   control_out_t ctrl_q;

   // funct3 map shared by OP and OP-IMM
   function automatic alu_op_t arith_op(input logic [2:0] funct3,
                                        input logic       sub_sel,
                                        input logic       sra_sel);
      alu_op_t op;
      op = ALU_ADD;
      case (funct3)
         F3_ADD_SUB: op = sub_sel ? ALU_SUB : ALU_ADD;
         F3_SLL:     op = ALU_SLL;
         F3_SLT:     op = ALU_SLT;
         F3_SLTU:    op = ALU_SLTU;
         F3_XOR:     op = ALU_XOR;
         F3_SR:      op = sra_sel ? ALU_SRA : ALU_SRL;
         F3_OR:      op = ALU_OR;
         F3_AND:     op = ALU_AND;
         default:    op = ALU_ADD;
      endcase
      return op;
   endfunction

   always_comb begin
      ctrl_next = '0;  // MEM_NOP, WB_ALU, CSR_NOP, no exception
      unique case (instr_i.opcode)
         OPC_LOAD: begin
            ctrl_next.mem_to_reg   = 1'b1;
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            ctrl_next.reg_write    = 1'b1;
            case (instr_i.funct3)
               F3_LB:  ctrl_next.mem_type = MEM_LB;
               F3_LH:  ctrl_next.mem_type = MEM_LH;
               F3_LW:  ctrl_next.mem_type = MEM_LW;
               F3_LBU: ctrl_next.mem_type = MEM_LBU;
               F3_LHU: ctrl_next.mem_type = MEM_LHU;
               default: begin
                  ctrl_next.inst_invalid = 1'b1;
                  ctrl_next.exc_cause    = EXC_ILLEGAL;
               end
            endcase
         end
         OPC_STORE: begin
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            case (instr_i.funct3)
               F3_SB: ctrl_next.mem_type = MEM_SB;
               F3_SH: ctrl_next.mem_type = MEM_SH;
               F3_SW: ctrl_next.mem_type = MEM_SW;
               default: begin
                  ctrl_next.inst_invalid = 1'b1;
                  ctrl_next.exc_cause    = EXC_ILLEGAL;
               end
            endcase
         end
         OPC_MISC_MEM: begin
            ctrl_next.alu_op = ALU_ADD;  // FENCE runs as a NOP
         end
         OPC_OP_IMM: begin
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.reg_write    = 1'b1;
            // No SUBI, imm[10] is funct7[5] for shifts
            ctrl_next.alu_op = arith_op(instr_i.funct3, 1'b0, imm_i[10]);
         end
         OPC_OP: begin
            ctrl_next.reg_write = 1'b1;
            ctrl_next.alu_op    = arith_op(instr_i.funct3,
                                           instr_i.funct7[5],
                                           instr_i.funct7[5]);
         end
         OPC_AUIPC: begin
            ctrl_next.alu_from_pc  = 1'b1;
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            ctrl_next.reg_write    = 1'b1;
         end
         OPC_LUI: begin
            ctrl_next.wb_sel       = WB_IMM;
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            ctrl_next.reg_write    = 1'b1;
         end
         OPC_BRANCH: begin
            ctrl_next.is_branch = 1'b1;
            case (instr_i.funct3)
               F3_BEQ:  ctrl_next.alu_op = ALU_CE;
               F3_BNE:  ctrl_next.alu_op = ALU_CNE;
               F3_BLT:  ctrl_next.alu_op = ALU_SLT;
               F3_BGE:  ctrl_next.alu_op = ALU_CGE;
               F3_BLTU: ctrl_next.alu_op = ALU_SLTU;
               F3_BGEU: ctrl_next.alu_op = ALU_CGEU;
               default: begin
                  ctrl_next.inst_invalid = 1'b1;
                  ctrl_next.exc_cause    = EXC_ILLEGAL;
               end
            endcase
         end
         OPC_JALR: begin
            ctrl_next.wb_sel       = WB_PC4;  // Link address
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            ctrl_next.reg_write    = 1'b1;
            ctrl_next.is_jalr      = 1'b1;
         end
         OPC_JAL: begin
            ctrl_next.wb_sel       = WB_PC4;
            ctrl_next.alu_from_pc  = 1'b1;
            ctrl_next.alu_from_imm = 1'b1;
            ctrl_next.alu_op       = ALU_ADD;
            ctrl_next.reg_write    = 1'b1;
            ctrl_next.is_jal       = 1'b1;
         end
         OPC_SYSTEM: begin
            ctrl_next.wb_sel = WB_CSR;
            ctrl_next.alu_op = ALU_ADD;
            case (instr_i.funct3)
               F3_PRIV: begin
                  case (imm_i[2:0])
                     SYS_ECALL: begin
                        ctrl_next.inst_priv   = 1'b1;
                        ctrl_next.exc_request = 1'b1;
                        ctrl_next.exc_cause   = EXC_ECALL;
                     end
                     SYS_EBREAK: begin
                        ctrl_next.inst_priv   = 1'b1;
                        ctrl_next.exc_request = 1'b1;
                        ctrl_next.exc_cause   = EXC_BREAK;
                     end
                     SYS_MRET: ctrl_next.exc_ret = 1'b1;
                     SYS_WFI:  ctrl_next.exc_ret = 1'b0;  // Nothing to wait for here
                     default: begin
                        ctrl_next.inst_invalid = 1'b1;
                        ctrl_next.exc_cause    = EXC_ILLEGAL;
                     end
                  endcase
               end
               F3_CSRRW, F3_CSRRWI: ctrl_next.csr_op = CSR_RW;
               F3_CSRRS, F3_CSRRSI: ctrl_next.csr_op = CSR_RS;
               F3_CSRRC, F3_CSRRCI: ctrl_next.csr_op = CSR_RC;
               default: begin
                  ctrl_next.inst_invalid = 1'b1;
                  ctrl_next.exc_cause    = EXC_ILLEGAL;
               end
            endcase
            if (ctrl_next.csr_op != CSR_NOP) begin
               ctrl_next.reg_write    = 1'b1;
               ctrl_next.csr_from_reg = ~instr_i.funct3[2];  // Immediate forms have bit 2 set
            end
         end
         default: begin
            ctrl_next.inst_invalid = 1'b1;
            ctrl_next.exc_cause    = EXC_ILLEGAL;
         end
      endcase
   end

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ctrl_q <= '0;
      end else if (decode_i) begin
         ctrl_q <= ctrl_next;
      end
   end

   assign control_o = ctrl_q;

endmodule

// File: verilog/decode_stage.sv
`timescale 1ns/1ns

module decode_stage import isa_pkg::*, ctrl_pkg::*; (
   input  logic            clk,
   input  logic            rst_n_i,
   input  logic            decode_i,
   input  logic [XLEN-1:0] instr_i,
   output logic            valid_o,
   output decoded_instr_t  fields_o,
   output logic [XLEN-1:0] imm_o,
   output control_out_t    control_o
);

   decoded_instr_t  dec_fields;
   logic [XLEN-1:0] dec_imm;

   decoded_instr_t  fields_q;
   logic [XLEN-1:0] imm_q;
   logic            valid_q;

   instr_decoder instr_decoder_i (
      .instr_i  (instr_i),
      .fields_o (dec_fields),
      .imm_o    (dec_imm)
   );

   // Holds its own control register, loaded on the same edge as below
   control_unit control_unit_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .decode_i  (decode_i),
      .instr_i   (dec_fields),
      .imm_i     (dec_imm),
      .control_o (control_o)
   );

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         fields_q <= '0;
         imm_q    <= '0;
      end else if (decode_i) begin
         fields_q <= dec_fields;
         imm_q    <= dec_imm;
      end
   end

   // One cycle pulse per decoded instruction
   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else begin
         valid_q <= decode_i;
      end
   end

   assign valid_o  = valid_q;
   assign fields_o = fields_q;
   assign imm_o    = imm_q;

endmodule

// File: testbench/decode_checker.sv
`timescale 1ns/1ns

module decode_checker import ctrl_pkg::*; (
   input logic         clk,
   input logic         rst_n_i,
   input logic         decode_i,
   input logic         valid_i,
   input control_out_t control_i
);

   // valid_o is the strobe delayed by one cycle
   a_valid_follows: assert property (@(posedge clk) disable iff (!rst_n_i)
      decode_i |=> valid_i)
      else $error("valid_o low one cycle after decode_i");

   a_valid_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
      !decode_i |=> !valid_i)
      else $error("valid_o high without decode_i one cycle before");

   a_exc_exclusive: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(control_i.inst_invalid && control_i.exc_request))
      else $error("inst_invalid and exc_request both set");

   a_store_no_write: assert property (@(posedge clk) disable iff (!rst_n_i)
      control_i.mem_type inside {MEM_SB, MEM_SH, MEM_SW} |-> !control_i.reg_write)
      else $error("reg_write set for a store");

endmodule

bind decode_stage decode_checker decode_checker_i (
   .clk       (clk),
   .rst_n_i   (rst_n_i),
   .decode_i  (decode_i),
   .valid_i   (valid_o),
   .control_i (control_o)
);

// File: testbench/tb_decode_stage.sv
`timescale 1ns/1ns

module tb_decode_stage import isa_pkg::*, ctrl_pkg::*; ();

   localparam int WAIT_LIMIT = 20;

   logic            clk;
   logic            rst_n_i;
   logic            decode_i;
   logic [XLEN-1:0] instr_i;
   logic            valid_o;
   decoded_instr_t  fields_o;
   logic [XLEN-1:0] imm_o;
   control_out_t    control_o;

   decode_stage decode_stage_i (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .decode_i  (decode_i),
      .instr_i   (instr_i),
      .valid_o   (valid_o),
      .fields_o  (fields_o),
      .imm_o     (imm_o),
      .control_o (control_o)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;
   end

   function automatic logic [31:0] enc_r(input logic [6:0] f7, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3,
                                         input logic [4:0] rd, input opcode_t opc);
      return {f7, rs2, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] enc_i(input logic [11:0] imm, input logic [4:0] rs1,
                                         input logic [2:0] f3, input logic [4:0] rd,
                                         input opcode_t opc);
      return {imm, rs1, f3, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] enc_s(input logic [11:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[11:5], rs2, rs1, f3, imm[4:0], OPC_STORE, 2'b11};
   endfunction

   function automatic logic [31:0] enc_b(input logic [12:0] imm, input logic [4:0] rs2,
                                         input logic [4:0] rs1, input logic [2:0] f3);
      return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], OPC_BRANCH, 2'b11};
   endfunction

   function automatic logic [31:0] enc_u(input logic [19:0] imm, input logic [4:0] rd,
                                         input opcode_t opc);
      return {imm, rd, opc, 2'b11};
   endfunction

   function automatic logic [31:0] enc_j(input logic [20:0] imm, input logic [4:0] rd);
      return {imm[20], imm[10:1], imm[11], imm[19:12], rd, OPC_JAL, 2'b11};
   endfunction

   function automatic decoded_instr_t fields_of(input opcode_t opc, input logic [2:0] f3,
                                                input logic [6:0] f7, input logic [4:0] rs1,
                                                input logic [4:0] rs2, input logic [4:0] rd);
      return '{opcode: opc, funct3: f3, funct7: f7, rs1: rs1, rs2: rs2, rd: rd};
   endfunction

   // Everything else in the word stays zero
   function automatic control_out_t ctrl_of(input alu_op_t op, input logic rw,
                                            input logic from_imm, input logic from_pc,
                                            input wb_sel_t wb);
      control_out_t c;
      c = '0;
      c.alu_op       = op;
      c.reg_write    = rw;
      c.alu_from_imm = from_imm;
      c.alu_from_pc  = from_pc;
      c.wb_sel       = wb;
      return c;
   endfunction

   task automatic check_control(input control_out_t got, input control_out_t exp,
                                input string what);
      if (got !== exp) begin
         $display("ERROR control_o (%s): got %h, expected %h", what, got, exp);
         $display("TB FAILED");
         $fatal(1, "control_o mismatch");
      end
   endtask

   task automatic check_fields(input decoded_instr_t got, input decoded_instr_t exp,
                               input string what);
      if (got !== exp) begin
         $display("ERROR fields_o (%s): got %h, expected %h", what, got, exp);
         $display("TB FAILED");
         $fatal(1, "fields_o mismatch");
      end
   endtask

   task automatic check_imm(input logic [XLEN-1:0] got, input logic [XLEN-1:0] exp,
                            input string what);
      if (got !== exp) begin
         $display("ERROR imm_o (%s): got %h, expected %h", what, got, exp);
         $display("TB FAILED");
         $fatal(1, "imm_o mismatch");
      end
   endtask

   task automatic check_valid(input logic got, input logic exp, input string what);
      if (got !== exp) begin
         $display("ERROR valid_o (%s): got %h, expected %h", what, got, exp);
         $display("TB FAILED");
         $fatal(1, "valid_o mismatch");
      end
   endtask

   // Strobe for one cycle and return on the loading edge
   task automatic issue(input logic [31:0] instr);
      @(posedge clk);
      decode_i <= 1'b1;
      instr_i  <= instr;
      @(posedge clk);
      decode_i <= 1'b0;
   endtask

   task automatic wait_valid;
      int cycles;
      cycles = 0;
      @(negedge clk);
      while (!valid_o) begin
         if (cycles >= WAIT_LIMIT) begin
            $display("Timeout: valid_o stayed low for %0d cycles after a decode", WAIT_LIMIT);
            $display("TB FAILED");
            $fatal(1, "no valid_o");
         end else begin
            @(negedge clk);
            cycles++;
         end
      end
   endtask

   task automatic decode_check_ctrl(input logic [31:0] instr, input control_out_t exp,
                                    input string what);
      issue(instr);
      wait_valid();
      check_control(control_o, exp, what);
   endtask

   task automatic decode_check_imm(input logic [31:0] instr, input decoded_instr_t exp_f,
                                   input logic [XLEN-1:0] exp_imm, input string what);
      issue(instr);
      wait_valid();
      check_fields(fields_o, exp_f, what);
      check_imm(imm_o, exp_imm, what);
   endtask

   // Only the exception view of the word is defined for illegal encodings
   task automatic check_illegal(input logic [31:0] instr, input string what);
      control_out_t got;
      control_out_t exp;
      issue(instr);
      wait_valid();
      got = '0;
      got.inst_invalid = control_o.inst_invalid;
      got.exc_request  = control_o.exc_request;
      got.exc_ret      = control_o.exc_ret;
      got.mem_type     = control_o.mem_type;
      got.exc_cause    = control_o.exc_cause;
      exp = '0;
      exp.inst_invalid = 1'b1;
      exp.exc_cause    = EXC_ILLEGAL;
      check_control(got, exp, what);
   endtask

   task automatic test_reset;
      @(negedge clk);
      check_valid(valid_o, 1'b0, "reset");
      check_control(control_o, '0, "reset");
      check_fields(fields_o, '0, "reset");
      check_imm(imm_o, '0, "reset");
   endtask

   task automatic test_imm_fields;
      logic [31:0] r;
      logic [20:0] imm;
      repeat (6) begin
         r   = $urandom();
         imm = 21'($urandom());
         decode_check_imm(enc_i(imm[11:0], r[4:0], r[17:15], r[14:10], OPC_OP_IMM),
            fields_of(OPC_OP_IMM, r[17:15], imm[11:5], r[4:0], imm[4:0], r[14:10]),
            {{20{imm[11]}}, imm[11:0]}, "I-type");
         decode_check_imm(enc_s(imm[11:0], r[9:5], r[4:0], r[17:15]),
            fields_of(OPC_STORE, r[17:15], imm[11:5], r[4:0], r[9:5], imm[4:0]),
            {{20{imm[11]}}, imm[11:0]}, "S-type");
         decode_check_imm(enc_b({imm[12:1], 1'b0}, r[9:5], r[4:0], r[17:15]),
            fields_of(OPC_BRANCH, r[17:15], {imm[12], imm[10:5]}, r[4:0], r[9:5],
                      {imm[4:1], imm[11]}),
            {{19{imm[12]}}, imm[12:1], 1'b0}, "B-type");
         decode_check_imm(enc_u(imm[19:0], r[14:10], OPC_LUI),
            fields_of(OPC_LUI, imm[2:0], imm[19:13], imm[7:3], imm[12:8], r[14:10]),
            {imm[19:0], 12'h000}, "U-type");
         decode_check_imm(enc_j({imm[20:1], 1'b0}, r[14:10]),
            fields_of(OPC_JAL, imm[14:12], {imm[20], imm[10:5]}, imm[19:15],
                      {imm[4:1], imm[11]}, r[14:10]),
            {{11{imm[20]}}, imm[20:1], 1'b0}, "J-type");
      end
   endtask

   task automatic test_alu;
      alu_op_t     base_ops[8];
      logic [31:0] r;
      base_ops = '{ALU_ADD, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL, ALU_OR, ALU_AND};
      for (int f = 0; f < 8; f++) begin
         r = $urandom();
         decode_check_ctrl(enc_r(7'h00, r[16:12], r[21:17], 3'(f), r[26:22], OPC_OP),
            ctrl_of(base_ops[f], 1'b1, 1'b0, 1'b0, WB_ALU), "OP");
         // imm[10] held low so funct3 101 stays SRLI
         decode_check_ctrl(enc_i(r[11:0] & 12'hbff, r[21:17], 3'(f), r[26:22], OPC_OP_IMM),
            ctrl_of(base_ops[f], 1'b1, 1'b1, 1'b0, WB_ALU), "OP-IMM");
      end
      decode_check_ctrl(enc_r(7'h20, 5'd2, 5'd1, F3_ADD_SUB, 5'd3, OPC_OP),
         ctrl_of(ALU_SUB, 1'b1, 1'b0, 1'b0, WB_ALU), "SUB");
      decode_check_ctrl(enc_r(7'h20, 5'd2, 5'd1, F3_SR, 5'd3, OPC_OP),
         ctrl_of(ALU_SRA, 1'b1, 1'b0, 1'b0, WB_ALU), "SRA");
      decode_check_ctrl(enc_i(12'h407, 5'd1, F3_SR, 5'd3, OPC_OP_IMM),
         ctrl_of(ALU_SRA, 1'b1, 1'b1, 1'b0, WB_ALU), "SRAI");
   endtask

   task automatic test_mem_jump;
      logic [2:0]   load_f3[5];
      mem_type_t    load_mt[5];
      mem_type_t    store_mt[3];
      logic [2:0]   br_f3[6];
      alu_op_t      br_op[6];
      control_out_t e;
      load_f3  = '{3'b000, 3'b001, 3'b010, 3'b100, 3'b101};
      load_mt  = '{MEM_LB, MEM_LH, MEM_LW, MEM_LBU, MEM_LHU};
      store_mt = '{MEM_SB, MEM_SH, MEM_SW};
      br_f3    = '{3'b000, 3'b001, 3'b100, 3'b101, 3'b110, 3'b111};
      br_op    = '{ALU_CE, ALU_CNE, ALU_SLT, ALU_CGE, ALU_SLTU, ALU_CGEU};
      for (int k = 0; k < 5; k++) begin
         e = ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b0, WB_ALU);
         e.mem_to_reg = 1'b1;
         e.mem_type   = load_mt[k];
         decode_check_ctrl(enc_i(12'h010, 5'd5, load_f3[k], 5'd6, OPC_LOAD), e, "load");
      end
      for (int k = 0; k < 3; k++) begin
         e = ctrl_of(ALU_ADD, 1'b0, 1'b1, 1'b0, WB_ALU);
         e.mem_type = store_mt[k];
         decode_check_ctrl(enc_s(12'hff8, 5'd7, 5'd5, 3'(k)), e, "store");
      end
      for (int k = 0; k < 6; k++) begin
         e = ctrl_of(br_op[k], 1'b0, 1'b0, 1'b0, WB_ALU);
         e.is_branch = 1'b1;
         decode_check_ctrl(enc_b(13'h1ffc, 5'd2, 5'd1, br_f3[k]), e, "branch");
      end
      decode_check_ctrl(enc_u(20'hdead0, 5'd9, OPC_LUI),
         ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b0, WB_IMM), "LUI");
      decode_check_ctrl(enc_u(20'h00042, 5'd9, OPC_AUIPC),
         ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b1, WB_ALU), "AUIPC");
      e = ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b1, WB_PC4);
      e.is_jal = 1'b1;
      decode_check_ctrl(enc_j(21'h1ff800, 5'd1), e, "JAL");
      e = ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b0, WB_PC4);
      e.is_jalr = 1'b1;
      decode_check_ctrl(enc_i(12'h004, 5'd1, 3'b000, 5'd1, OPC_JALR), e, "JALR");
      decode_check_ctrl(enc_i(12'h0ff, 5'd0, 3'b000, 5'd0, OPC_MISC_MEM),
         ctrl_of(ALU_ADD, 1'b0, 1'b0, 1'b0, WB_ALU), "FENCE");
   endtask

   task automatic test_system;
      csr_op_t      ops[3];
      control_out_t e;
      ops = '{CSR_RW, CSR_RS, CSR_RC};
      e = ctrl_of(ALU_ADD, 1'b0, 1'b0, 1'b0, WB_CSR);
      e.inst_priv   = 1'b1;
      e.exc_request = 1'b1;
      e.exc_cause   = EXC_ECALL;
      decode_check_ctrl(enc_i(12'h000, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM), e, "ECALL");
      e.exc_cause = EXC_BREAK;
      decode_check_ctrl(enc_i(12'h001, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM), e, "EBREAK");
      e = ctrl_of(ALU_ADD, 1'b0, 1'b0, 1'b0, WB_CSR);
      e.exc_ret = 1'b1;
      decode_check_ctrl(enc_i(12'h302, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM), e, "MRET");
      decode_check_ctrl(enc_i(12'h105, 5'd0, F3_PRIV, 5'd0, OPC_SYSTEM),
         ctrl_of(ALU_ADD, 1'b0, 1'b0, 1'b0, WB_CSR), "WFI");
      for (int k = 0; k < 6; k++) begin
         e = ctrl_of(ALU_ADD, 1'b1, 1'b0, 1'b0, WB_CSR);
         e.csr_op       = ops[k % 3];
         e.csr_from_reg = (k < 3);
         decode_check_ctrl(enc_i(12'h340, 5'd4, 3'(k < 3 ? k + 1 : k + 2), 5'd8, OPC_SYSTEM),
            e, "CSR");
      end
      check_illegal(enc_i(12'h000, 5'd1, 3'b011, 5'd2, OPC_LOAD), "load funct3 011");
      check_illegal(enc_s(12'h000, 5'd1, 5'd2, 3'b011), "store funct3 011");
      check_illegal(enc_b(13'h0000, 5'd1, 5'd2, 3'b010), "branch funct3 010");
      check_illegal(enc_i(12'h000, 5'd0, 3'b100, 5'd0, OPC_SYSTEM), "SYSTEM funct3 100");
      check_illegal(32'h0000_007f, "unused opcode");  // Opcode bits 11111
   endtask

   task automatic test_hold_back_to_back;
      logic [31:0]    sub_w;
      logic [31:0]    addi_w;
      logic [31:0]    lui_w;
      logic [19:0]    u;
      control_out_t   sub_ctrl;
      decoded_instr_t sub_fields;
      u          = 20'h12345;
      sub_w      = enc_r(7'h20, 5'd6, 5'd5, F3_ADD_SUB, 5'd7, OPC_OP);
      addi_w     = enc_i(12'h800, 5'd9, F3_ADD_SUB, 5'd10, OPC_OP_IMM);
      lui_w      = enc_u(u, 5'd8, OPC_LUI);
      sub_ctrl   = ctrl_of(ALU_SUB, 1'b1, 1'b0, 1'b0, WB_ALU);
      sub_fields = fields_of(OPC_OP, F3_ADD_SUB, 7'h20, 5'd5, 5'd6, 5'd7);
      issue(sub_w);
      wait_valid();
      check_control(control_o, sub_ctrl, "before hold");
      check_fields(fields_o, sub_fields, "before hold");
      check_imm(imm_o, 32'h0000_0000, "before hold");  // OP has no immediate
      @(posedge clk);
      instr_i <= lui_w;  // New word without a strobe
      repeat (4) begin
         @(negedge clk);
         check_valid(valid_o, 1'b0, "hold");
         check_control(control_o, sub_ctrl, "hold");
         check_fields(fields_o, sub_fields, "hold");
         check_imm(imm_o, 32'h0000_0000, "hold");
      end
      @(posedge clk);
      decode_i <= 1'b1;
      instr_i  <= addi_w;
      @(posedge clk);
      instr_i  <= lui_w;
      @(negedge clk);
      check_valid(valid_o, 1'b1, "first of pair");
      check_control(control_o, ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b0, WB_ALU), "first of pair");
      check_fields(fields_o, fields_of(OPC_OP_IMM, 3'b000, 7'h40, 5'd9, 5'd0, 5'd10),
                   "first of pair");
      check_imm(imm_o, 32'hffff_f800, "first of pair");
      @(posedge clk);
      decode_i <= 1'b0;
      @(negedge clk);
      check_valid(valid_o, 1'b1, "second of pair");
      check_control(control_o, ctrl_of(ALU_ADD, 1'b1, 1'b1, 1'b0, WB_IMM), "second of pair");
      check_fields(fields_o, fields_of(OPC_LUI, u[2:0], u[19:13], u[7:3], u[12:8], 5'd8),
                   "second of pair");
      check_imm(imm_o, {u, 12'h000}, "second of pair");
      @(negedge clk);
      check_valid(valid_o, 1'b0, "after pair");
   endtask

   initial begin
      void'($urandom(88514));
      rst_n_i  <= 1'b0;
      decode_i <= 1'b0;
      instr_i  <= '0;
      repeat (5) @(posedge clk);
      rst_n_i <= 1'b1;
      test_reset();
      test_imm_fields();
      test_alu();
      test_mem_jump();
      test_system();
      test_hold_back_to_back();
      $display("TB PASSED");
      $finish;
   end

endmodule

// File: tb.f
verilog/isa_pkg.sv
verilog/ctrl_pkg.sv
verilog/instr_decoder.sv
verilog/control_unit.sv
verilog/decode_stage.sv
testbench/decode_checker.sv
testbench/tb_decode_stage.sv

// File: Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert
TOP       = tb_decode_stage
FILELIST  = tb.f
BUILD_DIR = obj_dir

SOURCES   = $(shell cat $(FILELIST))
SIM       = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

# Exit status of the simulation is the result
run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(BUILD_DIR)
